/* filelist.f */
+incdir+logic
logic/chanlink_evt_pkg.sv
logic/chanlink_frame_pkg.sv
logic/chanlink_fifo.sv
logic/frame_seq_counter.sv
logic/frame_fsm.sv
logic/frame_assembler.sv
logic/chanlink_readout.sv
tests/chanlink_readout_assertions.sv
tests/chanlink_readout_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the chanlink readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module chanlink_readout_tb \
	-Mdir obj_dir -o chanlink_readout_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/chanlink_readout_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tests/chanlink_readout_tb.sv */
`timescale 1ns/1ns
`include "chanlink_settings.svh"

module chanlink_readout_tb;

	localparam int FRAME_WORDS = `CHL_SEQ_LAST + 1;
	localparam int WAIT_LIMIT  = 2000;     // Cycles per wait

	logic                         RCLK;
	logic                         RST_RESYNC;
	logic                         evt_wr_i;
	chanlink_evt_pkg::evt_entry_t evt_data_i;
	logic                         l1a_wr_i;
	logic                         l1a_match_i;
	chanlink_evt_pkg::l1a_entry_t l1a_data_i;
	logic                         warn_i;
	logic [6:0]                   samp_max_i;
	logic                         evt_credit_o;
	logic                         l1a_credit_o;
	logic [15:0]                  dout_o;
	logic                         dvalid_o;
	logic                         last_wrd_o;

	integer seed;
	int     checks;
	int     errors;
	int     assert_fails;
	int     frames_seen;
	int     evt_spent;
	int     evt_returned;
	int     l1a_spent;
	int     l1a_returned;

	chanlink_evt_pkg::evt_entry_t ev_samp [3][`CHL_DATA_WORDS];
	chanlink_evt_pkg::l1a_entry_t ev_l1a [3];
	logic [15:0]                  frame_word [FRAME_WORDS];
	logic                         frame_last [FRAME_WORDS];

	chanlink_readout uut (
		.RCLK         (RCLK),
		.RST_RESYNC   (RST_RESYNC),
		.evt_wr_i     (evt_wr_i),
		.evt_data_i   (evt_data_i),
		.l1a_wr_i     (l1a_wr_i),
		.l1a_match_i  (l1a_match_i),
		.l1a_data_i   (l1a_data_i),
		.warn_i       (warn_i),
		.samp_max_i   (samp_max_i),
		.evt_credit_o (evt_credit_o),
		.l1a_credit_o (l1a_credit_o),
		.dout_o       (dout_o),
		.dvalid_o     (dvalid_o),
		.last_wrd_o   (last_wrd_o)
	);

	bind chanlink_readout chanlink_readout_assertions assertions (
		.RCLK         (RCLK),
		.RST_RESYNC   (RST_RESYNC),
		.evt_wr_i     (evt_wr_i),
		.l1a_wr_i     (l1a_wr_i),
		.l1a_match_i  (l1a_match_i),
		.evt_count_i  (evt_count),
		.l1a_count_i  (l1a_count),
		.l1a_credit_i (l1a_credit_o),
		.dvalid_i     (dvalid_o),
		.last_wrd_i   (last_wrd_o)
	);

	always #2 RCLK = ~RCLK;               // 4 ns period

	// Credits handed back by the readout
	always @(posedge RCLK) begin
		if (RST_RESYNC) begin
			evt_returned <= 0;
			l1a_returned <= 0;
		end else begin
			if (evt_credit_o) begin
				evt_returned <= evt_returned + 1;
			end
			if (l1a_credit_o) begin
				l1a_returned <= l1a_returned + 1;
			end
		end
	end

	function automatic int evt_credits();
		return `CHL_EVT_DEPTH - evt_spent + evt_returned;
	endfunction

	function automatic int l1a_credits();
		return `CHL_L1A_DEPTH - l1a_spent + l1a_returned;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checking and waiting
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: %s expected 0x%0h actual 0x%0h",
				test, what, expected, actual);
		end
	endtask

	task automatic give_up(input string what);
		$display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic check_quiet(input string test);
		check_value(test, "dvalid/last/evt credit/l1a credit", 32'h0,
			{28'h0, dvalid_o, last_wrd_o, evt_credit_o, l1a_credit_o});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Writer side
	//////////////////////////////////////////////////////////////////////

	task automatic write_l1a(input int slot, input logic phase, input logic matched);
		chanlink_evt_pkg::l1a_entry_t rec;
		int                           wait_cnt;
		rec.phase     = phase;
		rec.match_cnt = 12'($random(seed));
		rec.l1a_cnt   = 24'($random(seed));
		wait_cnt      = 0;
		@(posedge RCLK);
		while (matched && l1a_credits() == 0) begin
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT) begin
				give_up("L1A credit return");
			end
			@(posedge RCLK);
		end
		l1a_wr_i    <= 1'b1;
		l1a_match_i <= matched;
		l1a_data_i  <= rec;
		if (matched) begin
			ev_l1a[slot] = rec;
			l1a_spent++;
		end
		@(posedge RCLK);
		l1a_wr_i    <= 1'b0;
		l1a_match_i <= 1'b0;
	endtask

	task automatic write_samples(input int slot, input bit quiet);
		chanlink_evt_pkg::evt_entry_t entry;
		int                           wait_cnt;
		for (int i = 0; i < `CHL_DATA_WORDS; i++) begin
			entry.ovlp   = 1'($random(seed));
			entry.sample = 12'($random(seed));
			ev_samp[slot][i] = entry;
			wait_cnt = 0;
			@(posedge RCLK);
			if (quiet) begin
				check_quiet("quiet_after_reset");
			end
			while (evt_credits() == 0) begin
				evt_wr_i <= 1'b0;     // Stall until a credit comes back
				wait_cnt++;
				if (wait_cnt > WAIT_LIMIT) begin
					give_up("event credit return");
				end
				@(posedge RCLK);
			end
			evt_wr_i   <= 1'b1;
			evt_data_i <= entry;
			evt_spent++;
		end
		@(posedge RCLK);
		evt_wr_i <= 1'b0;
	endtask

	task automatic write_event(input int slot, input logic phase, input bit quiet);
		write_l1a(slot, phase, 1'b1);
		write_samples(slot, quiet);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reader side
	//////////////////////////////////////////////////////////////////////

	task automatic collect_frame();
		int wait_cnt;
		int n;
		wait_cnt = 0;
		@(posedge RCLK);
		while (!dvalid_o) begin
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT) begin
				give_up("frame start");
			end
			@(posedge RCLK);
		end
		n        = 0;
		wait_cnt = 0;
		while (n < FRAME_WORDS) begin
			if (dvalid_o) begin
				frame_word[n] = dout_o;
				frame_last[n] = last_wrd_o;
				n++;
			end else begin
				errors++;
				$display("dvalid_o dropped after %0d words of frame %0d", n, frames_seen);
			end
			wait_cnt++;
			if (wait_cnt > 2 * FRAME_WORDS) begin
				give_up("frame end");
			end
			if (n < FRAME_WORDS) begin
				@(posedge RCLK);
			end
		end
		frames_seen++;
	endtask

	function automatic logic [15:0] expected_sample(input int slot, input int s,
		input logic [6:0] smax);
		logic serial;
		serial = 1'b0;
		if (s >= `CHL_PHASE_FIRST && s <= `CHL_PHASE_LAST) begin
			serial = ev_l1a[slot].phase;
		end else if (s >= `CHL_SMAX_FIRST && s <= `CHL_SMAX_LAST) begin
			serial = (smax == 7'(`CHL_SMAX_FLAG));
		end
		return {1'b0, ~ev_samp[slot][s].ovlp, serial, 1'b0, ev_samp[slot][s].sample};
	endfunction

	task automatic check_data_words(input string test, input int slot, input logic [6:0] smax);
		for (int s = 0; s < `CHL_DATA_WORDS; s++) begin
			check_value(test, $sformatf("word %0d", s),
				32'(expected_sample(slot, s, smax)), 32'(frame_word[s]));
		end
		check_value(test, "word 97", 32'(`CHL_WORD_HDR), 32'(frame_word[`CHL_SEQ_HDR]));
		check_value(test, "word 99", 32'(`CHL_WORD_END), 32'(frame_word[`CHL_SEQ_LAST]));
		for (int s = 0; s < FRAME_WORDS; s++) begin
			check_value(test, $sformatf("last_wrd_o at word %0d", s),
				32'(s == `CHL_SEQ_LAST), 32'(frame_last[s]));
		end
	endtask

	task automatic check_crc_word(input string test, input int slot);
		logic [14:0] crc;
		crc = '0;
		for (int s = 0; s < `CHL_DATA_WORDS; s++) begin
			crc = chanlink_frame_pkg::crc15_d13({1'b0, ev_samp[slot][s].sample}, crc);
		end
		check_value(test, "word 96", 32'({1'b0, crc}), 32'(frame_word[`CHL_SEQ_CRC]));
	endtask

	task automatic check_l1a_word(input string test, input int slot, input int occ,
		input logic warn);
		check_value(test, "word 98",
			32'({4'h7, ev_l1a[slot].l1a_cnt[5:0], 5'(occ), warn}),
			32'(frame_word[`CHL_SEQ_L1A]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_quiet_after_reset();
		for (int c = 0; c < 20; c++) begin
			@(posedge RCLK);
			check_quiet("quiet_after_reset");
		end
		write_event(0, 1'b0, 1'b1);
		collect_frame();
	endtask

	task automatic test_data_words();
		write_event(0, 1'b0, 1'b0);
		collect_frame();
		check_data_words("data_words", 0, samp_max_i);
	endtask

	task automatic test_crc_word();
		write_event(0, 1'($random(seed)), 1'b0);
		collect_frame();
		check_crc_word("crc_word", 0);
	endtask

	task automatic test_serial_windows();
		@(posedge RCLK);
		samp_max_i <= 7'd15;
		write_event(0, 1'b1, 1'b0);
		collect_frame();
		check_data_words("serial_set", 0, 7'd15);
		for (int s = `CHL_PHASE_FIRST; s <= `CHL_SMAX_LAST; s++) begin
			if (s <= `CHL_PHASE_LAST || s >= `CHL_SMAX_FIRST) begin
				check_value("serial_set", $sformatf("serial bit of word %0d", s),
					32'h1, 32'(frame_word[s][13]));
			end
		end
		@(posedge RCLK);
		samp_max_i <= 7'd14;
		write_event(0, 1'b0, 1'b0);
		collect_frame();
		check_data_words("serial_clear", 0, 7'd14);
		for (int s = `CHL_PHASE_FIRST; s <= `CHL_SMAX_LAST; s++) begin
			check_value("serial_clear", $sformatf("serial bit of word %0d", s),
				32'h0, 32'(frame_word[s][13]));
		end
	endtask

	task automatic test_l1a_trailer();
		@(posedge RCLK);
		samp_max_i <= 7'd0;
		warn_i     <= 1'b1;
		write_l1a(0, 1'($random(seed)), 1'b1);
		write_l1a(0, 1'b1, 1'b0);             // Unmatched, must be dropped
		write_l1a(1, 1'($random(seed)), 1'b1);
		write_l1a(2, 1'($random(seed)), 1'b1);
		fork
			begin
				write_samples(0, 1'b0);
				write_samples(1, 1'b0);
				write_samples(2, 1'b0);
			end
			begin
				for (int k = 0; k < 3; k++) begin
					collect_frame();
					check_data_words($sformatf("l1a_trailer frame %0d", k), k, 7'd0);
					check_crc_word($sformatf("l1a_trailer frame %0d", k), k);
					check_l1a_word($sformatf("l1a_trailer frame %0d", k), k, 3 - k, 1'b1);
				end
			end
		join
	endtask

	task automatic test_credit_return();
		check_value("credit_return", "event credit pulses",
			32'(frames_seen * `CHL_DATA_WORDS), 32'(evt_returned));
		check_value("credit_return", "L1A credit pulses", 32'(frames_seen), 32'(l1a_returned));
		check_value("credit_return", "event credits held", 32'(`CHL_EVT_DEPTH),
			32'(evt_credits()));
		check_value("credit_return", "L1A credits held", 32'(`CHL_L1A_DEPTH),
			32'(l1a_credits()));
	endtask

	initial begin
		seed         = 32'h978ddae5;
		RCLK         = 1'b0;
		RST_RESYNC   = 1'b1;
		evt_wr_i     = 1'b0;
		evt_data_i   = '0;
		l1a_wr_i     = 1'b0;
		l1a_match_i  = 1'b0;
		l1a_data_i   = '0;
		warn_i       = 1'b0;
		samp_max_i   = 7'd0;
		checks       = 0;
		errors       = 0;
		frames_seen  = 0;
		evt_spent    = 0;
		l1a_spent    = 0;
		repeat (16) @(posedge RCLK);
		RST_RESYNC <= 1'b0;

		test_quiet_after_reset();
		test_data_words();
		test_crc_word();
		test_serial_windows();
		test_l1a_trailer();
		test_credit_return();

		assert_fails = uut.assertions.fail_count;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* tests/chanlink_readout_assertions.sv */
`timescale 1ns/1ns
`include "chanlink_settings.svh"

module chanlink_readout_assertions (
	input  logic                      RCLK,
	input  logic                      RST_RESYNC,
	input  logic                      evt_wr_i,
	input  logic                      l1a_wr_i,
	input  logic                      l1a_match_i,
	input  logic [`CHL_EVT_CNT_W-1:0] evt_count_i,
	input  logic [`CHL_L1A_CNT_W-1:0] l1a_count_i,
	input  logic                      l1a_credit_i,
	input  logic                      dvalid_i,
	input  logic                      last_wrd_i
);

	int unsigned fail_count = 0;

	// A writer holding a credit never meets a full buffer
	evt_write_has_credit: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		evt_wr_i |-> (evt_count_i != `CHL_EVT_CNT_W'(`CHL_EVT_DEPTH)))
	else begin
		fail_count++;
		$error("Event write while the event buffer is full");
	end

	l1a_write_has_credit: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		(l1a_wr_i && l1a_match_i) |-> (l1a_count_i != `CHL_L1A_CNT_W'(`CHL_L1A_DEPTH)))
	else begin
		fail_count++;
		$error("L1A write while the L1A buffer is full");
	end

	l1a_credit_single: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		l1a_credit_i |=> !l1a_credit_i)     // One trigger record per frame
	else begin
		fail_count++;
		$error("L1A credit pulse longer than one cycle");
	end

	frame_length: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		$rose(dvalid_i) |-> ##(`CHL_SEQ_LAST) last_wrd_i)
	else begin
		fail_count++;
		$error("Frame does not end on its 100th word");
	end

	frame_gap: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		last_wrd_i |=> !dvalid_i)           // Idle cycle between frames
	else begin
		fail_count++;
		$error("No idle cycle after a frame");
	end

endmodule

/* logic/chanlink_readout.sv */
`timescale 1ns/1ns
`include "chanlink_settings.svh"

module chanlink_readout (
	input  logic                         RCLK,
	input  logic                         RST_RESYNC,
	input  logic                         evt_wr_i,
	input  chanlink_evt_pkg::evt_entry_t evt_data_i,
	input  logic                         l1a_wr_i,
	input  logic                         l1a_match_i,
	input  chanlink_evt_pkg::l1a_entry_t l1a_data_i,
	input  logic                         warn_i,
	input  logic [6:0]                   samp_max_i,
	output logic                         evt_credit_o,
	output logic                         l1a_credit_o,
	output logic [15:0]                  dout_o,
	output logic                         dvalid_o,
	output logic                         last_wrd_o
);

	chanlink_evt_pkg::evt_entry_t evt_rd_data;
	chanlink_evt_pkg::l1a_entry_t l1a_rd_data;
	logic [`CHL_EVT_CNT_W-1:0]    evt_count;
	logic [`CHL_L1A_CNT_W-1:0]    l1a_count;
	logic                         l1a_empty;
	logic                         seq_run;
	logic                         evt_pop;
	logic                         l1a_pop;
	logic                         word_valid;
	logic [`CHL_SEQ_W-1:0]        seq;
	logic                         data_phase;
	logic                         frame_last;

	//////////////////////////////////////////////////////////////////////
	// Event and trigger buffers
	//////////////////////////////////////////////////////////////////////

	chanlink_fifo #(
		.DEPTH  (`CHL_EVT_DEPTH),
		.CNT_W  (`CHL_EVT_CNT_W),
		.DATA_W ($bits(chanlink_evt_pkg::evt_entry_t))
	) evt_fifo (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.wr_i       (evt_wr_i),
		.wr_data_i  (evt_data_i),
		.rd_i       (evt_pop),
		.rd_data_o  (evt_rd_data),
		.count_o    (evt_count),
		.empty_o    (),
		.credit_o   (evt_credit_o)
	);

	chanlink_fifo #(
		.DEPTH  (`CHL_L1A_DEPTH),
		.CNT_W  (`CHL_L1A_CNT_W),
		.DATA_W ($bits(chanlink_evt_pkg::l1a_entry_t))
	) l1a_fifo (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.wr_i       (l1a_wr_i & l1a_match_i),   // Matched triggers only
		.wr_data_i  (l1a_data_i),
		.rd_i       (l1a_pop),
		.rd_data_o  (l1a_rd_data),
		.count_o    (l1a_count),
		.empty_o    (l1a_empty),
		.credit_o   (l1a_credit_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Frame control and assembly
	//////////////////////////////////////////////////////////////////////

	frame_seq_counter seq_counter (
		.RCLK         (RCLK),
		.RST_RESYNC   (RST_RESYNC),
		.run_i        (seq_run),
		.seq_o        (seq),
		.data_phase_o (data_phase),
		.frame_last_o (frame_last)
	);

	frame_fsm fsm (
		.RCLK         (RCLK),
		.RST_RESYNC   (RST_RESYNC),
		.evt_count_i  (evt_count),
		.l1a_empty_i  (l1a_empty),
		.data_phase_i (data_phase),
		.frame_last_i (frame_last),
		.seq_run_o    (seq_run),
		.evt_pop_o    (evt_pop),
		.l1a_pop_o    (l1a_pop),
		.word_valid_o (word_valid)
	);

	frame_assembler assembler (
		.RCLK         (RCLK),
		.RST_RESYNC   (RST_RESYNC),
		.seq_i        (seq),
		.word_valid_i (word_valid),
		.evt_entry_i  (evt_rd_data),
		.l1a_entry_i  (l1a_rd_data),
		.l1a_count_i  (l1a_count),
		.warn_i       (warn_i),
		.samp_max_i   (samp_max_i),
		.dout_o       (dout_o),
		.dvalid_o     (dvalid_o),
		.last_wrd_o   (last_wrd_o)
	);

endmodule

/* logic/frame_assembler.sv */
`timescale 1ns/1ns
`include "chanlink_settings.svh"

module frame_assembler (
	input  logic                      RCLK,
	input  logic                      RST_RESYNC,
	input  logic [`CHL_SEQ_W-1:0]     seq_i,
	input  logic                      word_valid_i,
	input  chanlink_evt_pkg::evt_entry_t evt_entry_i,
	input  chanlink_evt_pkg::l1a_entry_t l1a_entry_i,
	input  logic [`CHL_L1A_CNT_W-1:0] l1a_count_i,
	input  logic                      warn_i,
	input  logic [6:0]                samp_max_i,
	output logic [15:0]               dout_o,
	output logic                      dvalid_o,
	output logic                      last_wrd_o
);

	logic [`CHL_SEQ_W-1:0]          seq_d;
	logic                           valid_d;
	logic [14:0]                    crc;
	logic                           serial;
	logic                           in_phase_win;
	logic                           in_smax_win;
	chanlink_frame_pkg::frame_word_u word_u;
	logic [15:0]                    word_nxt;

	//////////////////////////////////////////////////////////////////////
	// Stage 1: position lined up with FIFO read data
	//////////////////////////////////////////////////////////////////////

	assign in_phase_win = (seq_d >= `CHL_SEQ_W'(`CHL_PHASE_FIRST)) &&
		(seq_d <= `CHL_SEQ_W'(`CHL_PHASE_LAST));
	assign in_smax_win  = (seq_d >= `CHL_SEQ_W'(`CHL_SMAX_FIRST)) &&
		(seq_d <= `CHL_SEQ_W'(`CHL_SMAX_LAST));

	always_comb begin
		if (in_phase_win) begin
			serial = l1a_entry_i.phase;
		end else if (in_smax_win) begin
			serial = (samp_max_i == 7'(`CHL_SMAX_FLAG));
		end else begin
			serial = 1'b0;
		end
	end

	always_comb begin
		word_u.samp.zero_hi = 1'b0;
		word_u.samp.ovlp_n  = ~evt_entry_i.ovlp;
		word_u.samp.serial  = serial;
		word_u.samp.zero_lo = 1'b0;
		word_u.samp.sample  = evt_entry_i.sample;
		if (seq_d == `CHL_SEQ_W'(`CHL_SEQ_CRC)) begin
			word_u.chk.zero  = 1'b0;
			word_u.chk.value = crc;      // Covers all 96 samples by now
		end
	end

	always_comb begin
		case (seq_d)
			`CHL_SEQ_W'(`CHL_SEQ_HDR):  word_nxt = `CHL_WORD_HDR;
			`CHL_SEQ_W'(`CHL_SEQ_L1A):  word_nxt = {4'h7, l1a_entry_i.l1a_cnt[5:0],
				l1a_count_i, warn_i};
			`CHL_SEQ_W'(`CHL_SEQ_LAST): word_nxt = `CHL_WORD_END;
			default:                    word_nxt = word_u;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 2: output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			seq_d      <= '0;
			valid_d    <= 1'b0;
			crc        <= '0;
			dvalid_o   <= 1'b0;
			last_wrd_o <= 1'b0;
		end else begin
			seq_d   <= seq_i;
			valid_d <= word_valid_i;
			if (!valid_d) begin
				crc <= '0;              // Cleared in the gap between frames
			end else if (seq_d < `CHL_SEQ_W'(`CHL_DATA_WORDS)) begin
				crc <= chanlink_frame_pkg::crc15_d13({1'b0, evt_entry_i.sample}, crc);
			end
			dvalid_o   <= valid_d;
			last_wrd_o <= valid_d && (seq_d == `CHL_SEQ_W'(`CHL_SEQ_LAST));
		end
	end

	always_ff @(posedge RCLK) begin
		dout_o <= word_nxt;
	end

endmodule

/* logic/frame_fsm.sv */
`timescale 1ns/1ns
`include "chanlink_settings.svh"

module frame_fsm (
	input  logic                      RCLK,
	input  logic                      RST_RESYNC,
	input  logic [`CHL_EVT_CNT_W-1:0] evt_count_i,
	input  logic                      l1a_empty_i,
	input  logic                      data_phase_i,
	input  logic                      frame_last_i,
	output logic                      seq_run_o,
	output logic                      evt_pop_o,
	output logic                      l1a_pop_o,
	output logic                      word_valid_o
);

	chanlink_frame_pkg::fsm_state_t state;
	chanlink_frame_pkg::fsm_state_t state_nxt;
	logic                           evt_ready;
	logic                           sending;

	// Full event and its trigger record buffered
	assign evt_ready = !l1a_empty_i &&
		(evt_count_i >= `CHL_EVT_CNT_W'(`CHL_DATA_WORDS));

	assign sending      = (state == chanlink_frame_pkg::SEND);
	assign seq_run_o    = sending;
	assign word_valid_o = sending;
	assign evt_pop_o    = sending && data_phase_i;
	assign l1a_pop_o    = sending && frame_last_i;   // Trigger consumed on word 99

	always_comb begin
		state_nxt = state;
		case (state)
			chanlink_frame_pkg::IDLE: begin
				if (evt_ready) begin
					state_nxt = chanlink_frame_pkg::SEND;
				end
			end
			chanlink_frame_pkg::SEND: begin
				if (frame_last_i) begin
					state_nxt = chanlink_frame_pkg::IDLE;
				end
			end
			default: state_nxt = chanlink_frame_pkg::IDLE;
		endcase
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= chanlink_frame_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

/* logic/frame_seq_counter.sv */
`timescale 1ns/1ns
`include "chanlink_settings.svh"

module frame_seq_counter (
	input  logic                  RCLK,
	input  logic                  RST_RESYNC,
	input  logic                  run_i,
	output logic [`CHL_SEQ_W-1:0] seq_o,
	output logic                  data_phase_o,
	output logic                  frame_last_o
);

	assign data_phase_o = (seq_o < `CHL_SEQ_W'(`CHL_DATA_WORDS));
	assign frame_last_o = (seq_o == `CHL_SEQ_W'(`CHL_SEQ_LAST));

	// Sits at zero between frames
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			seq_o <= '0;
		end else if (run_i && !frame_last_o) begin
			seq_o <= seq_o + 1'b1;
		end else begin
			seq_o <= '0;
		end
	end

endmodule

/* logic/chanlink_fifo.sv */
`timescale 1ns/1ns

module chanlink_fifo #(
	parameter int DEPTH  = 16,
	parameter int CNT_W  = 5,
	parameter int DATA_W = 8
) (
	input  logic              RCLK,
	input  logic              RST_RESYNC,
	input  logic              wr_i,
	input  logic [DATA_W-1:0] wr_data_i,
	input  logic              rd_i,
	output logic [DATA_W-1:0] rd_data_o,
	output logic [CNT_W-1:0]  count_o,
	output logic              empty_o,
	output logic              credit_o
);

	localparam int AW = $clog2(DEPTH);

	logic [DATA_W-1:0] mem [DEPTH];
	logic [AW-1:0]     wr_ptr;
	logic [AW-1:0]     rd_ptr;
	logic              full;
	logic              do_wr;
	logic              do_rd;

	assign full    = (count_o == CNT_W'(DEPTH));
	assign empty_o = (count_o == '0);
	assign do_wr   = wr_i && !full;         // Write without credit is lost
	assign do_rd   = rd_i && !empty_o;

	always_ff @(posedge RCLK) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data_i;
		end
		rd_data_o <= mem[rd_ptr];           // Head entry, one cycle behind
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count_o  <= '0;
			credit_o <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o;
			endcase
			credit_o <= do_rd;              // One credit back per pop
		end
	end

endmodule

/* logic/chanlink_frame_pkg.sv */
`include "chanlink_settings.svh"

package chanlink_frame_pkg;

	typedef struct packed {
		logic                   zero_hi;
		logic                   ovlp_n;     // Active low overlap
		logic                   serial;
		logic                   zero_lo;
		logic [`CHL_DATA_W-1:0] sample;
	} sample_word_t;

	typedef struct packed {
		logic        zero;
		logic [14:0] value;
	} crc_word_t;

	typedef union packed {
		sample_word_t samp;
		crc_word_t    chk;
	} frame_word_u;

	typedef enum logic {
		IDLE,
		SEND
	} fsm_state_t;

	// CRC15 over a 13 bit word, one step per sample
	function automatic logic [14:0] crc15_d13(input logic [12:0] d, input logic [14:0] c);
		logic [14:0] n;
		n[0] = d[0] ^ c[2];
		for (int i = 1; i < 13; i++) begin
			n[i] = d[i-1] ^ d[i] ^ c[i+1] ^ c[i+2];
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage

/* logic/chanlink_evt_pkg.sv */
`include "chanlink_settings.svh"

package chanlink_evt_pkg;

	// One sample as stored in the event buffer
	typedef struct packed {
		logic                   ovlp;       // Sample shared with previous event
		logic [`CHL_DATA_W-1:0] sample;
	} evt_entry_t;

	// Trigger record, stored only on an L1A match
	typedef struct packed {
		logic                   phase;
		logic [`CHL_DATA_W-1:0] match_cnt;
		logic [23:0]            l1a_cnt;
	} l1a_entry_t;

endpackage

/* logic/chanlink_settings.svh */
`ifndef CHANLINK_SETTINGS_SVH
`define CHANLINK_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Buffer sizes
//////////////////////////////////////////////////////////////////////

`define CHL_DATA_W       12       // ADC sample
`define CHL_EVT_DEPTH    128
`define CHL_EVT_CNT_W    8        // Holds 0..128
`define CHL_L1A_DEPTH    16
`define CHL_L1A_CNT_W    5        // Holds 0..16

//////////////////////////////////////////////////////////////////////
// Frame layout
//////////////////////////////////////////////////////////////////////

`define CHL_SEQ_W        7
`define CHL_DATA_WORDS   96       // Sample words per frame
`define CHL_SEQ_CRC      96
`define CHL_SEQ_HDR      97
`define CHL_SEQ_L1A      98
`define CHL_SEQ_LAST     99

// Serial flag windows inside the sample words
`define CHL_PHASE_FIRST  72
`define CHL_PHASE_LAST   77
`define CHL_SMAX_FIRST   90
`define CHL_SMAX_LAST    95
`define CHL_SMAX_FLAG    15

`define CHL_WORD_HDR     16'h700C
`define CHL_WORD_END     16'h7FFF

`endif
